// File: qdr_sniff_consts.svh
`ifndef QDR_SNIFF_CONSTS_SVH
`define QDR_SNIFF_CONSTS_SVH

// qdr word address width.
`define QDR_ADDR_W 21
// one qdr half-word, four data bytes plus four parity bits.
`define QDR_DATA_W 36
// write enables per half, each one covers 18 data bits.
`define QDR_BW_W 2
// read strobe to data-valid, in qdr_clk cycles.
`define QDR_LATENCY 10

// host byte window for the backdoor.
`define SNIFF_BASE 32'h0001_0000
// 2^21 words of 8 bytes past the base.
`define SNIFF_HIGH (`SNIFF_BASE + 32'h0100_0000)

// backdoor request queue depth.
`define REQ_FIFO_DEPTH 4

`endif

// File: qdr_sniff_pkg.sv
`default_nettype none

`include "qdr_sniff_consts.svh"

package qdr_sniff_pkg;

  ////////////////////
  // basic qdr fields
  ////////////////////

  // word address on the qdr controller port.
  typedef logic [`QDR_ADDR_W-1:0] qdr_addr_t;

  // one 36-bit half, data at 0, 9, 18 and 27, parity above each byte.
  typedef logic [`QDR_DATA_W-1:0] qdr_half_t;

  // full 72-bit word, index 1 is the upper half.
  typedef qdr_half_t [1:0] qdr_word_t;

  // byte-write enables, two per half.
  typedef logic [1:0][`QDR_BW_W-1:0] qdr_be_t;

  ////////////////////
  // command bundles
  ////////////////////

  // fabric and master side command.
  // strobes are levels, held by the fabric until slave_ack.
  typedef struct packed {
    qdr_addr_t addr;
    logic      wr;
    logic      rd;
    qdr_word_t data;
    qdr_be_t   be;
  } qdr_cmd_t;

  // one queued backdoor access.
  typedef struct packed {
    qdr_addr_t addr;
    logic      rnw;
    qdr_word_t data;
    qdr_be_t   be;
  } bd_req_t;

endpackage

`default_nettype wire

// File: qdr_backdoor_host.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniff_consts.svh"

module qdr_backdoor_host (
  input  wire                             qdr_clk,
  input  wire                             qdr_rst,
  input  wire                             host_en,
  input  wire                             host_rnw,
  input  wire  [31:0]                     host_addr,
  input  wire  [31:0]                     host_wdata,
  input  wire  [3:0]                      host_be,
  output logic [31:0]                     host_rdata,
  output logic                            host_ack,
  output logic                            push,
  output qdr_sniff_pkg::bd_req_t          push_data,
  input  wire                             full,
  input  wire  qdr_sniff_pkg::qdr_word_t  bd_q,
  input  wire                             bd_qvld
);

  logic                       in_win;
  logic [31:0]                local_addr;
  logic                       half_sel;
  qdr_sniff_pkg::qdr_half_t   half_d;
  logic [`QDR_BW_W-1:0]       half_be;
  qdr_sniff_pkg::bd_req_t     req_d;

  logic                       pend_vld;
  qdr_sniff_pkg::bd_req_t     pend_req;
  logic                       pend_half;
  logic                       rd_wait;
  logic                       ack_q;
  logic [31:0]                rdata_q;
  qdr_sniff_pkg::qdr_half_t   rd_half;
  logic [31:0]                rd_word;

  ////////////////////
  // address decode
  ////////////////////

  always_comb begin
    in_win     = (host_addr >= `SNIFF_BASE) && (host_addr < `SNIFF_HIGH);
    local_addr = host_addr - `SNIFF_BASE;
    // bit 2 picks the half, bits 23..3 the qdr word.
    half_sel   = local_addr[2];

    // bytes land on 9-bit lanes, parity left zero.
    half_d = '0;
    for (int i = 0; i < 4; i++) begin
      half_d[9*i +: 8] = host_wdata[8*i +: 8];
    end
    // each enable spans two bytes.
    for (int j = 0; j < `QDR_BW_W; j++) begin
      half_be[j] = host_be[2*j] | host_be[2*j+1];
    end

    req_d               = '0;
    req_d.addr          = local_addr[`QDR_ADDR_W+2:3];
    req_d.rnw           = host_rnw;
    req_d.data[half_sel] = half_d;
    // other half stays masked.
    req_d.be[half_sel]  = half_be;
  end

  ////////////////////
  // request hand-off
  ////////////////////

  // retries every cycle while the queue is full.
  assign push      = pend_vld & ~full;
  assign push_data = pend_req;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      pend_vld <= 1'b0;
      rd_wait  <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (host_en && in_win) begin
        pend_vld <= 1'b1;
      end else if (push) begin
        pend_vld <= 1'b0;
      end
      // a read is queued, now wait for its data.
      if (push && pend_req.rnw) begin
        rd_wait <= 1'b1;
      end else if (rd_wait && bd_qvld) begin
        rd_wait <= 1'b0;
      end
      // miss on the window acks next cycle.
      if ((host_en && !in_win) || (rd_wait && bd_qvld)) begin
        ack_q <= 1'b1;
      end
    end
  end

  ////////////////////
  // read return
  ////////////////////

  always_comb begin
    rd_half = bd_q[pend_half];
    for (int i = 0; i < 4; i++) begin
      rd_word[8*i +: 8] = rd_half[9*i +: 8];
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (host_en) begin
      pend_req  <= req_d;
      pend_half <= half_sel;
    end
    if (host_en && !in_win) begin
      rdata_q <= '0;
    end else if (rd_wait && bd_qvld) begin
      rdata_q <= rd_word;
    end
  end

  assign host_rdata = rdata_q;
  // writes ack in the push cycle.
  assign host_ack   = ack_q | (push & ~pend_req.rnw);

endmodule

`default_nettype wire

// File: qdr_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module qdr_req_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  wire   qdr_clk,
  input  wire   qdr_rst,
  input  wire   push,
  input  wire T push_data,
  input  wire   pop,
  output T      head,
  output logic  empty,
  output logic  full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem [DEPTH];
  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;
  // wrap bits tell full from empty when the indices meet.
  logic          wr_wrap;
  logic          rd_wrap;
  logic          do_push;
  logic          do_pop;

  ////////////////////
  // occupancy
  ////////////////////

  assign empty   = (wr_idx == rd_idx) && (wr_wrap == rd_wrap);
  assign full    = (wr_idx == rd_idx) && (wr_wrap != rd_wrap);
  // overflow and underflow are dropped.
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wr_idx  <= '0;
      wr_wrap <= 1'b0;
      rd_idx  <= '0;
      rd_wrap <= 1'b0;
    end else begin
      if (do_push) begin
        if (wr_idx == AW'(DEPTH - 1)) begin
          wr_idx  <= '0;
          wr_wrap <= ~wr_wrap;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_idx == AW'(DEPTH - 1)) begin
          rd_idx  <= '0;
          rd_wrap <= ~rd_wrap;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge qdr_clk) begin
    if (do_push) begin
      mem[wr_idx] <= push_data;
    end
  end

  // show-ahead, oldest entry always visible.
  assign head = mem[rd_idx];

endmodule

`default_nettype wire

// File: qdr_sniff_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniff_consts.svh"

module qdr_sniff_arb (
  input  wire                             qdr_clk,
  input  wire                             qdr_rst,
  input  wire  qdr_sniff_pkg::qdr_cmd_t   slave_cmd,
  output logic                            slave_ack,
  output qdr_sniff_pkg::qdr_word_t        slave_rd_data,
  output logic                            slave_rd_dvld,
  input  wire                             bd_empty,
  input  wire  qdr_sniff_pkg::bd_req_t    bd_head,
  output logic                            bd_pop,
  output qdr_sniff_pkg::qdr_word_t        bd_q,
  output logic                            bd_qvld,
  output qdr_sniff_pkg::qdr_cmd_t         master_cmd,
  input  wire  qdr_sniff_pkg::qdr_word_t  master_rd_data,
  input  wire                             master_rd_dvld
);

  // one-hot arbiter states.
  typedef enum logic [3:0] {
    SLAVE         = 4'h1,
    SLAVE_WAIT    = 4'h2,
    BACKDOOR      = 4'h4,
    BACKDOOR_WAIT = 4'h8
  } arb_state_t;

  arb_state_t              arb_state;
  arb_state_t              arb_next;
  logic                    slave_strb;
  logic                    bd_grant;
  logic                    bd_rd_issue;
  logic                    fab_data_sel;
  // bit n set means the read issued n+1 cycles ago was backdoor.
  logic [`QDR_LATENCY-1:0] bd_rd_rec;

  ////////////////////
  // arbitration
  ////////////////////

  assign slave_strb = slave_cmd.wr | slave_cmd.rd;

  always_comb begin
    arb_next = arb_state;
    case (arb_state)
      SLAVE: begin
        // a live fabric strobe gets one more cycle first.
        if (!bd_empty) begin
          arb_next = slave_strb ? SLAVE_WAIT : BACKDOOR;
        end
      end
      SLAVE_WAIT: begin
        arb_next = BACKDOOR;
      end
      BACKDOOR: begin
        // only one backdoor slot per grant.
        arb_next = BACKDOOR_WAIT;
      end
      BACKDOOR_WAIT: begin
        arb_next = SLAVE;
      end
      default: begin
        arb_next = SLAVE;
      end
    endcase
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      arb_state <= SLAVE;
    end else begin
      arb_state <= arb_next;
    end
  end

  ////////////////////
  // master port mux
  ////////////////////

  assign slave_ack    = (arb_state == SLAVE);
  assign bd_grant     = (arb_state == BACKDOOR) & ~bd_empty;
  assign bd_pop       = bd_grant;
  assign bd_rd_issue  = bd_grant & bd_head.rnw;
  // write payload follows the fabric until the backdoor slot.
  assign fab_data_sel = (arb_state == SLAVE) || (arb_state == SLAVE_WAIT);

  always_comb begin
    master_cmd.addr = slave_ack ? slave_cmd.addr : bd_head.addr;
    master_cmd.wr   = (slave_ack & slave_cmd.wr) | (bd_grant & ~bd_head.rnw);
    master_cmd.rd   = (slave_ack & slave_cmd.rd) | bd_rd_issue;
    if (fab_data_sel) begin
      master_cmd.data = slave_cmd.data;
      master_cmd.be   = slave_cmd.be;
    end else begin
      master_cmd.data = bd_head.data;
      master_cmd.be   = bd_head.be;
    end
  end

  ////////////////////
  // read steering
  ////////////////////

  // tracks every issued read, fabric reads shift in a zero.
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      bd_rd_rec <= '0;
    end else begin
      bd_rd_rec <= {bd_rd_rec[`QDR_LATENCY-2:0], bd_rd_issue};
    end
  end

  // data is shared, the valid goes one way only.
  assign slave_rd_data = master_rd_data;
  assign bd_q          = master_rd_data;
  assign slave_rd_dvld = master_rd_dvld & ~bd_rd_rec[`QDR_LATENCY-1];
  assign bd_qvld       = master_rd_dvld &  bd_rd_rec[`QDR_LATENCY-1];

endmodule

`default_nettype wire

// File: qdr_sniffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniff_consts.svh"

module qdr_sniffer (
  input  wire                             qdr_clk,
  input  wire                             qdr_rst,
  // fabric side.
  input  wire  qdr_sniff_pkg::qdr_cmd_t   slave_cmd,
  output logic                            slave_ack,
  output qdr_sniff_pkg::qdr_word_t        slave_rd_data,
  output logic                            slave_rd_dvld,
  // host register side.
  input  wire                             host_en,
  input  wire                             host_rnw,
  input  wire  [31:0]                     host_addr,
  input  wire  [31:0]                     host_wdata,
  input  wire  [3:0]                      host_be,
  output logic [31:0]                     host_rdata,
  output logic                            host_ack,
  // qdr controller side.
  output qdr_sniff_pkg::qdr_cmd_t         master_cmd,
  input  wire  qdr_sniff_pkg::qdr_word_t  master_rd_data,
  input  wire                             master_rd_dvld
);

  logic                      bd_push;
  qdr_sniff_pkg::bd_req_t    bd_push_data;
  logic                      bd_full;
  logic                      bd_empty;
  qdr_sniff_pkg::bd_req_t    bd_head;
  logic                      bd_pop;
  qdr_sniff_pkg::qdr_word_t  bd_q;
  logic                      bd_qvld;

  // host accesses become queued backdoor requests.
  qdr_backdoor_host i_host (
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .host_en    (host_en),
    .host_rnw   (host_rnw),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_be    (host_be),
    .host_rdata (host_rdata),
    .host_ack   (host_ack),
    .push       (bd_push),
    .push_data  (bd_push_data),
    .full       (bd_full),
    .bd_q       (bd_q),
    .bd_qvld    (bd_qvld)
  );

  qdr_req_fifo #(
    .T     (qdr_sniff_pkg::bd_req_t),
    .DEPTH (`REQ_FIFO_DEPTH)
  ) i_req_fifo (
    .qdr_clk   (qdr_clk),
    .qdr_rst   (qdr_rst),
    .push      (bd_push),
    .push_data (bd_push_data),
    .pop       (bd_pop),
    .head      (bd_head),
    .empty     (bd_empty),
    .full      (bd_full)
  );

  // fabric first, one backdoor slot when the queue is busy.
  qdr_sniff_arb i_arb (
    .qdr_clk        (qdr_clk),
    .qdr_rst        (qdr_rst),
    .slave_cmd      (slave_cmd),
    .slave_ack      (slave_ack),
    .slave_rd_data  (slave_rd_data),
    .slave_rd_dvld  (slave_rd_dvld),
    .bd_empty       (bd_empty),
    .bd_head        (bd_head),
    .bd_pop         (bd_pop),
    .bd_q           (bd_q),
    .bd_qvld        (bd_qvld),
    .master_cmd     (master_cmd),
    .master_rd_data (master_rd_data),
    .master_rd_dvld (master_rd_dvld)
  );

endmodule

`default_nettype wire

// File: tb_qdr_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniff_consts.svh"

module tb_qdr_mem_model #(
  parameter int AW = 6
) (
  input  wire                             qdr_clk,
  input  wire                             qdr_rst,
  input  wire  qdr_sniff_pkg::qdr_cmd_t   cmd,
  output qdr_sniff_pkg::qdr_word_t        rd_data,
  output logic                            rd_dvld
);

  qdr_sniff_pkg::qdr_word_t  mem [2**AW];
  // read data and valid, one stage per cycle of latency.
  qdr_sniff_pkg::qdr_word_t  rd_pipe [`QDR_LATENCY];
  logic [`QDR_LATENCY-1:0]   vld_pipe;
  logic [AW-1:0]             idx;

  // upper address bits alias.
  assign idx = cmd.addr[AW-1:0];

  // fill pattern changes with every address bit.
  initial begin
    for (int i = 0; i < 2**AW; i++) begin
      mem[i][0] = {4'h5, 32'(i) ^ 32'h0f1e_2d3c};
      mem[i][1] = {4'ha, ~32'(i)};
    end
  end

  ////////////////////
  // write port
  ////////////////////

  // one enable per 18-bit lane.
  always @(posedge qdr_clk) begin
    if (cmd.wr) begin
      for (int h = 0; h < 2; h++) begin
        for (int b = 0; b < `QDR_BW_W; b++) begin
          if (cmd.be[h][b]) begin
            mem[idx][h][18*b +: 18] <= cmd.data[h][18*b +: 18];
          end
        end
      end
    end
  end

  ////////////////////
  // read port
  ////////////////////

  always @(posedge qdr_clk) begin
    if (qdr_rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`QDR_LATENCY-2:0], cmd.rd};
    end
    rd_pipe[0] <= mem[idx];
    for (int i = 1; i < `QDR_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // data valid QDR_LATENCY edges after the strobe.
  assign rd_data = rd_pipe[`QDR_LATENCY-1];
  assign rd_dvld = vld_pipe[`QDR_LATENCY-1];

endmodule

`default_nettype wire

// File: qdr_sniff_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniff_consts.svh"

module qdr_sniff_asserts (
  input wire                           qdr_clk,
  input wire                           qdr_rst,
  input wire qdr_sniff_pkg::qdr_cmd_t  master_cmd,
  input wire                           bd_pop,
  input wire [3:0]                     arb_state,
  input wire                           slave_rd_dvld,
  input wire                           bd_qvld
);

  // one-hot code of the backdoor slot.
  localparam logic [3:0] ST_BACKDOOR = 4'h4;

  // one strobe at a time on the controller port.
  a_one_strobe: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    !(master_cmd.wr && master_cmd.rd))
    else $error("master wr and rd high together");

  // single pop per grant.
  a_pop_pulse: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    bd_pop |=> !bd_pop)
    else $error("bd_pop longer than one cycle");

  // the backdoor slot always finds a request and pops it.
  a_pop_state: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    bd_pop == (arb_state == ST_BACKDOOR))
    else $error("bd_pop and the backdoor slot disagree");

  // each return goes one way, to the side that issued the read.
  a_ret_excl: assert property (@(posedge qdr_clk) disable iff (qdr_rst)
    (slave_rd_dvld || bd_qvld) |->
      ((slave_rd_dvld != bd_qvld) &&
       (bd_qvld == $past(bd_pop && master_cmd.rd, `QDR_LATENCY))))
    else $error("read return steered to the wrong side");

  // first cycle out of reset is quiet.
  a_rst_quiet: assert property (@(posedge qdr_clk)
    (qdr_rst ##1 !qdr_rst) |-> (!master_cmd.wr && !master_cmd.rd))
    else $error("master strobe right after reset");

endmodule

bind qdr_sniff_arb qdr_sniff_asserts i_asserts (
  .qdr_clk       (qdr_clk),
  .qdr_rst       (qdr_rst),
  .master_cmd    (master_cmd),
  .bd_pop        (bd_pop),
  .arb_state     (arb_state),
  .slave_rd_dvld (slave_rd_dvld),
  .bd_qvld       (bd_qvld)
);

`default_nettype wire

// File: tb_qdr_sniffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "qdr_sniff_consts.svh"

module tb_qdr_sniffer;

  // model depth, tests stay in the low 64 words.
  localparam int MEM_AW = 6;
  // six tests take a few hundred cycles.
  localparam int TIMEOUT_CYC = 2000;
  // longest single wait, a backdoor read behind held strobes.
  localparam int WAIT_MAX = 4 * `QDR_LATENCY;

  logic                      qdr_clk;
  logic                      qdr_rst;
  qdr_sniff_pkg::qdr_cmd_t   slave_cmd;
  logic                      slave_ack;
  qdr_sniff_pkg::qdr_word_t  slave_rd_data;
  logic                      slave_rd_dvld;
  logic                      host_en;
  logic                      host_rnw;
  logic [31:0]               host_addr;
  logic [31:0]               host_wdata;
  logic [3:0]                host_be;
  logic [31:0]               host_rdata;
  logic                      host_ack;
  qdr_sniff_pkg::qdr_cmd_t   master_cmd;
  qdr_sniff_pkg::qdr_word_t  master_rd_data;
  logic                      master_rd_dvld;

  integer                    seed;
  int                        cyc;
  int                        err_cnt;
  int                        chk_cnt;
  int                        strb_cnt;
  string                     cur_test;
  // expected memory, updated in issue order.
  qdr_sniff_pkg::qdr_word_t  exp_mem [2**MEM_AW];
  // fabric reads in flight, data and due cycle.
  qdr_sniff_pkg::qdr_word_t  ret_data [$];
  int                        ret_cyc [$];

  qdr_sniffer i_dut (
    .qdr_clk        (qdr_clk),
    .qdr_rst        (qdr_rst),
    .slave_cmd      (slave_cmd),
    .slave_ack      (slave_ack),
    .slave_rd_data  (slave_rd_data),
    .slave_rd_dvld  (slave_rd_dvld),
    .host_en        (host_en),
    .host_rnw       (host_rnw),
    .host_addr      (host_addr),
    .host_wdata     (host_wdata),
    .host_be        (host_be),
    .host_rdata     (host_rdata),
    .host_ack       (host_ack),
    .master_cmd     (master_cmd),
    .master_rd_data (master_rd_data),
    .master_rd_dvld (master_rd_dvld)
  );

  tb_qdr_mem_model #(
    .AW (MEM_AW)
  ) i_mem (
    .qdr_clk (qdr_clk),
    .qdr_rst (qdr_rst),
    .cmd     (master_cmd),
    .rd_data (master_rd_data),
    .rd_dvld (master_rd_dvld)
  );

  initial begin
    qdr_clk = 1'b0;
    forever #20 qdr_clk = ~qdr_clk;
  end

  // cycle count, run limit.
  always @(posedge qdr_clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("run stopped after %0d cycles, a test hung", cyc);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_word(string name, qdr_sniff_pkg::qdr_word_t exp,
                            qdr_sniff_pkg::qdr_word_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(string name, logic [31:0] exp, logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Fail %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    chk_cnt++;
    if (act != exp) begin
      err_cnt++;
      $display("Fail %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  ////////////////////
  // expected values
  ////////////////////

  function automatic qdr_sniff_pkg::qdr_word_t rand_word();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[71:0];
  endfunction

  function automatic qdr_sniff_pkg::qdr_be_t rand_be();
    logic [31:0] r;
    r = $random(seed);
    return r[3:0];
  endfunction

  // one enable per 18-bit lane.
  function automatic qdr_sniff_pkg::qdr_word_t merge_word(qdr_sniff_pkg::qdr_word_t old_w,
    qdr_sniff_pkg::qdr_word_t new_w, qdr_sniff_pkg::qdr_be_t be);
    qdr_sniff_pkg::qdr_word_t res;
    res = old_w;
    for (int h = 0; h < 2; h++) begin
      for (int b = 0; b < 2; b++) begin
        if (be[h][b]) begin
          res[h][18*b +: 18] = new_w[h][18*b +: 18];
        end
      end
    end
    return res;
  endfunction

  // host bytes at 0, 9, 18 and 27 of half off[2], parity zero.
  function automatic void host_to_exp(logic [31:0] off, logic [31:0] v, logic [3:0] hbe);
    qdr_sniff_pkg::qdr_word_t w;
    qdr_sniff_pkg::qdr_be_t   be;
    w  = '0;
    be = '0;
    for (int i = 0; i < 4; i++) begin
      w[off[2]][9*i +: 8] = v[8*i +: 8];
    end
    be[off[2]] = {hbe[3] | hbe[2], hbe[1] | hbe[0]};
    exp_mem[off[MEM_AW+2:3]] = merge_word(exp_mem[off[MEM_AW+2:3]], w, be);
  endfunction

  function automatic logic [31:0] exp_host_rd(logic [31:0] off);
    logic [31:0] v;
    for (int i = 0; i < 4; i++) begin
      v[8*i +: 8] = exp_mem[off[MEM_AW+2:3]][off[2]][9*i +: 8];
    end
    return v;
  endfunction

  ////////////////////
  // drivers
  ////////////////////

  // strobe held until slave_ack, acc is the accept cycle.
  task automatic fabric_drive(qdr_sniff_pkg::qdr_cmd_t c, logic last, output int acc);
    int n;
    @(posedge qdr_clk);
    slave_cmd <= c;
    n = 0;
    do begin
      @(negedge qdr_clk);
      n++;
    end while (!slave_ack && n < WAIT_MAX);
    acc = cyc;
    if (!slave_ack) begin
      err_cnt++;
      $display("%s: slave_ack never came for a fabric strobe", cur_test);
    end
    if (last) begin
      @(posedge qdr_clk);
      slave_cmd <= '0;
      @(negedge qdr_clk);
    end
  endtask

  task automatic fabric_write(int a, qdr_sniff_pkg::qdr_word_t d, qdr_sniff_pkg::qdr_be_t be,
                              logic last, output int acc);
    qdr_sniff_pkg::qdr_cmd_t c;
    c      = '0;
    c.addr = qdr_sniff_pkg::qdr_addr_t'(a);
    c.wr   = 1'b1;
    c.data = d;
    c.be   = be;
    fabric_drive(c, last, acc);
    exp_mem[a] = merge_word(exp_mem[a], d, be);
  endtask

  // return is checked by the monitor below.
  task automatic fabric_read(int a, logic last, output int acc);
    qdr_sniff_pkg::qdr_cmd_t c;
    c      = '0;
    c.addr = qdr_sniff_pkg::qdr_addr_t'(a);
    c.rd   = 1'b1;
    fabric_drive(c, last, acc);
    ret_data.push_back(exp_mem[a]);
    ret_cyc.push_back(acc + `QDR_LATENCY);
  endtask

  // one-cycle host_en, lat counts cycles to host_ack.
  task automatic host_access(logic rnw, logic [31:0] addr, logic [31:0] wdata,
                             logic [3:0] be, output logic [31:0] rdata, output int lat);
    @(posedge qdr_clk);
    host_en    <= 1'b1;
    host_rnw   <= rnw;
    host_addr  <= addr;
    host_wdata <= wdata;
    host_be    <= be;
    @(posedge qdr_clk);
    host_en <= 1'b0;
    lat = 0;
    do begin
      @(negedge qdr_clk);
      lat++;
    end while (!host_ack && lat < WAIT_MAX);
    rdata = host_rdata;
    if (!host_ack) begin
      err_cnt++;
      $display("%s: host_ack never came", cur_test);
    end
  endtask

  task automatic host_write(logic [31:0] off, logic [31:0] v, logic [3:0] be);
    logic [31:0] rd;
    int          lat;
    host_access(1'b0, `SNIFF_BASE + off, v, be, rd, lat);
    host_to_exp(off, v, be);
  endtask

  task automatic host_read_check(logic [31:0] off);
    logic [31:0] rd;
    int          lat;
    host_access(1'b1, `SNIFF_BASE + off, '0, 4'hf, rd, lat);
    check_data({cur_test, " host read"}, exp_host_rd(off), rd);
  endtask

  task automatic drain_returns();
    int n;
    n = 0;
    while (ret_data.size() != 0 && n < WAIT_MAX) begin
      @(negedge qdr_clk);
      n++;
    end
    if (ret_data.size() != 0) begin
      err_cnt++;
      $display("%s: %0d fabric reads never returned", cur_test, ret_data.size());
      ret_data.delete();
      ret_cyc.delete();
    end
  endtask

  // master strobes and fabric returns, sampled mid-cycle.
  always @(negedge qdr_clk) begin
    if (!qdr_rst) begin
      if (master_cmd.wr || master_cmd.rd) begin
        strb_cnt++;
      end
      if (slave_rd_dvld) begin
        if (ret_data.size() == 0) begin
          err_cnt++;
          $display("%s: slave_rd_dvld with no fabric read in flight", cur_test);
        end else begin
          check_word({cur_test, " data"}, ret_data.pop_front(), slave_rd_data);
          check_count({cur_test, " latency"}, ret_cyc.pop_front(), cyc);
        end
      end
    end
  end

  ////////////////////
  // tests
  ////////////////////

  task automatic test_after_reset();
    cur_test = "test_after_reset";
    @(negedge qdr_clk);
    check_bit({cur_test, " slave_ack"}, 1'b1, slave_ack);
    check_bit({cur_test, " host_ack"}, 1'b0, host_ack);
    check_bit({cur_test, " slave_rd_dvld"}, 1'b0, slave_rd_dvld);
    check_bit({cur_test, " master wr"}, 1'b0, master_cmd.wr);
    check_bit({cur_test, " master rd"}, 1'b0, master_cmd.rd);
  endtask

  // full word first, then a random partial merge.
  task automatic test_fabric_rw();
    int acc;
    cur_test = "test_fabric_rw";
    for (int a = 4; a < 8; a++) begin
      fabric_write(a, rand_word(), '1, 1'b0, acc);
      fabric_write(a, rand_word(), rand_be(), 1'b0, acc);
    end
    for (int a = 4; a < 8; a++) begin
      fabric_read(a, a == 7, acc);
    end
    drain_returns();
  endtask

  task automatic test_host_rw();
    logic [31:0] offs [5] = '{32'h40, 32'h4c, 32'h50, 32'h54, 32'h58};
    int          acc;
    cur_test = "test_host_rw";
    for (int a = 8; a < 12; a++) begin
      fabric_write(a, rand_word(), '1, a == 11, acc);
    end
    for (int i = 0; i < 5; i++) begin
      host_write(offs[i], $random(seed), 4'hf);
    end
    // bytes 2 and 3 share one lane.
    host_write(offs[4], $random(seed), 4'b0100);
    for (int i = 0; i < 5; i++) begin
      host_read_check(offs[i]);
    end
    for (int a = 8; a < 12; a++) begin
      fabric_read(a, a == 11, acc);
    end
    drain_returns();
  endtask

  // fabric strobe lands as the backdoor request shows up.
  task automatic test_contention();
    qdr_sniff_pkg::qdr_word_t wa;
    qdr_sniff_pkg::qdr_word_t wb;
    logic [31:0]              hv;
    logic [31:0]              rd;
    int                       lat;
    int                       acc_a;
    int                       acc_b;
    cur_test = "test_contention";
    wa = rand_word();
    wb = rand_word();
    hv = $random(seed);
    fork
      host_access(1'b0, `SNIFF_BASE + 32'ha4, hv, 4'hf, rd, lat);
      begin
        repeat (2) @(posedge qdr_clk);
        fabric_write(20, wa, '1, 1'b0, acc_a);
        fabric_write(21, wb, '1, 1'b1, acc_b);
      end
    join
    // fabric write went first, backdoor write merged on top.
    host_to_exp(32'ha4, hv, 4'hf);
    check_count({cur_test, " second strobe held"}, acc_a + 4, acc_b);
    fabric_read(20, 1'b0, acc_a);
    fabric_read(21, 1'b1, acc_b);
    drain_returns();
    host_read_check(32'ha4);
  endtask

  task automatic test_interleave();
    logic [31:0] rd;
    int          lat;
    int          acc;
    cur_test = "test_interleave";
    for (int a = 24; a < 28; a++) begin
      fabric_write(a, rand_word(), '1, a == 27, acc);
    end
    host_write(32'hdc, $random(seed), 4'hf);
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          fabric_read(24 + (i % 4), i == 5, acc);
        end
      end
      begin
        @(posedge qdr_clk);
        host_access(1'b1, `SNIFF_BASE + 32'hdc, '0, 4'hf, rd, lat);
      end
    join
    check_data({cur_test, " host read"}, exp_host_rd(32'hdc), rd);
    drain_returns();
  endtask

  task automatic test_out_of_window();
    logic [31:0] rd;
    int          lat;
    int          n0;
    cur_test = "test_out_of_window";
    n0 = strb_cnt;
    // host_rdata still holds the last backdoor read here.
    host_access(1'b1, `SNIFF_HIGH, '0, 4'hf, rd, lat);
    check_count({cur_test, " read ack"}, 1, lat);
    check_data({cur_test, " read data"}, 32'h0, rd);
    host_access(1'b0, `SNIFF_BASE - 32'h8, 32'h1234_5678, 4'hf, rd, lat);
    check_count({cur_test, " write ack"}, 1, lat);
    repeat (4) @(negedge qdr_clk);
    check_count({cur_test, " master strobes"}, n0, strb_cnt);
  endtask

  initial begin
    seed       = 32'hd8e0;
    qdr_rst    = 1'b1;
    slave_cmd  = '0;
    host_en    = 1'b0;
    host_rnw   = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    repeat (4) @(posedge qdr_clk);
    qdr_rst <= 1'b0;
    test_after_reset();
    test_fabric_rw();
    test_host_rw();
    test_contention();
    test_interleave();
    test_out_of_window();
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
qdr_sniff_pkg.sv
qdr_backdoor_host.sv
qdr_req_fifo.sv
qdr_sniff_arb.sv
qdr_sniffer.sv
tb_qdr_mem_model.sv
qdr_sniff_asserts.sv
tb_qdr_sniffer.sv
